// ==== decode_stage.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_advance,
  input  logic                 i_bubble,
  input  logic                 i_flush,
  input  logic [`RV_XLEN-1:0]   i_instr,
  input  logic [`RV_XLEN-1:0]   i_pc,
  input  logic [`RV_XLEN-1:0]   i_rs1_data,
  input  logic [`RV_XLEN-1:0]   i_rs2_data,
  output logic [`RV_REG_AW-1:0] o_rs1,
  output logic [`RV_REG_AW-1:0] o_rs2,
  output rv_pkg::ctrl_t        o_ex_ctrl,
  output logic [`RV_XLEN-1:0]   o_ex_pc,
  output logic [`RV_XLEN-1:0]   o_ex_imm,
  output logic [`RV_XLEN-1:0]   o_ex_rs1_data,
  output logic [`RV_XLEN-1:0]   o_ex_rs2_data,
  output logic [`RV_REG_AW-1:0] o_ex_rs1,
  output logic [`RV_REG_AW-1:0] o_ex_rs2,
  output logic [`RV_REG_AW-1:0] o_ex_rd
);

  logic [2:0]            funct3;
  logic                  funct7_b5;
  logic [`RV_REG_AW-1:0] rd;
  rv_pkg::ctrl_t         ctrl;
  logic [`RV_XLEN-1:0]   imm;

  assign o_rs1     = i_instr[19:15];
  assign o_rs2     = i_instr[24:20];
  assign rd        = i_instr[11:7];
  assign funct3    = i_instr[14:12];
  assign funct7_b5 = i_instr[30];

  always_comb begin
    ctrl = '0;
    imm  = {{20{i_instr[31]}}, i_instr[31:20]}; // I-type unless overridden
    case (rv_pkg::opcode_e'(i_instr[6:0]))
      rv_pkg::op_lui: begin
        ctrl.alu_op   = rv_pkg::alu_pass_b;
        ctrl.use_imm  = 1'b1;
        ctrl.rd_valid = 1'b1;
        imm           = {i_instr[31:12], 12'b0};
      end
      rv_pkg::op_imm, rv_pkg::op_reg: begin
        ctrl.use_imm  = (i_instr[5] == 1'b0);
        ctrl.rd_valid = 1'b1;
        case (funct3)
          3'b000: begin
            if (i_instr[5] && funct7_b5) ctrl.alu_op = rv_pkg::alu_sub;
            else ctrl.alu_op = rv_pkg::alu_add;
          end
          3'b010: ctrl.alu_op = rv_pkg::alu_slt;
          3'b100: ctrl.alu_op = rv_pkg::alu_xor;
          3'b110: ctrl.alu_op = rv_pkg::alu_or;
          3'b111: ctrl.alu_op = rv_pkg::alu_and;
          default: ctrl = '0; // Shifts not supported
        endcase
      end
      rv_pkg::op_load: begin
        if (funct3 == 3'b010) begin // LW only
          ctrl.use_imm  = 1'b1;
          ctrl.mem_read = 1'b1;
          ctrl.rd_valid = 1'b1;
          ctrl.wb_sel   = rv_pkg::wb_mem;
        end
      end
      rv_pkg::op_store: begin
        if (funct3 == 3'b010) begin
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
        end
        imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
      end
      rv_pkg::op_branch: begin
        ctrl.use_pc    = 1'b1; // ALU forms the target
        ctrl.use_imm   = 1'b1;
        ctrl.is_branch = 1'b1;
        case (funct3)
          3'b000: ctrl.cmp_op = rv_pkg::cmp_eq;
          3'b001: ctrl.cmp_op = rv_pkg::cmp_ne;
          3'b100: ctrl.cmp_op = rv_pkg::cmp_lt;
          default: ctrl = '0;
        endcase
        imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
      end
      rv_pkg::op_jal: begin
        ctrl.use_pc   = 1'b1;
        ctrl.use_imm  = 1'b1;
        ctrl.is_jump  = 1'b1;
        ctrl.rd_valid = 1'b1;
        ctrl.wb_sel   = rv_pkg::wb_pc_plus4;
        imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
      end
      default: ;
    endcase
    if (rd == '0) ctrl.rd_valid = 1'b0; // x0 never written
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ex_ctrl <= '0;
    end else if (i_advance) begin
      if (i_flush || i_bubble) o_ex_ctrl <= '0;
      else o_ex_ctrl <= ctrl;
    end
  end

  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_ex_pc       <= i_pc;
      o_ex_imm      <= imm;
      o_ex_rs1_data <= i_rs1_data;
      o_ex_rs2_data <= i_rs2_data;
      o_ex_rs1      <= o_rs1;
      o_ex_rs2      <= o_rs2;
      o_ex_rd       <= rd;
    end
  end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module execute_stage (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_advance,
  input  rv_pkg::ctrl_t        i_ex_ctrl,
  input  logic [`RV_XLEN-1:0]   i_ex_pc,
  input  logic [`RV_XLEN-1:0]   i_ex_imm,
  input  logic [`RV_XLEN-1:0]   i_ex_rs1_data,
  input  logic [`RV_XLEN-1:0]   i_ex_rs2_data,
  input  logic [`RV_REG_AW-1:0] i_ex_rs1,
  input  logic [`RV_REG_AW-1:0] i_ex_rs2,
  input  logic [`RV_REG_AW-1:0] i_ex_rd,
  input  logic [`RV_REG_AW-1:0] i_wb_rd,
  input  logic                 i_wb_we,
  input  logic [`RV_XLEN-1:0]   i_wb_value,
  output logic                 o_redirect,
  output logic [`RV_XLEN-1:0]   o_target,
  output rv_pkg::ctrl_t        o_mem_ctrl,
  output logic [`RV_XLEN-1:0]   o_mem_alu,
  output logic [`RV_XLEN-1:0]   o_mem_store_data,
  output logic [`RV_XLEN-1:0]   o_mem_pc,
  output logic [`RV_REG_AW-1:0] o_mem_rd
);

  logic [`RV_XLEN-1:0] mem_value;
  logic [`RV_XLEN-1:0] fwd_rs1, fwd_rs2;
  logic [`RV_XLEN-1:0] alu_a, alu_b, alu_out;
  logic                cmp_true;

  // JAL in MEM forwards its link value
  assign mem_value = (o_mem_ctrl.wb_sel == rv_pkg::wb_pc_plus4) ? o_mem_pc + `RV_PC_STEP
                                                                 : o_mem_alu;

  always_comb begin
    if (o_mem_ctrl.rd_valid && o_mem_rd != '0 && o_mem_rd == i_ex_rs1) fwd_rs1 = mem_value;
    else if (i_wb_we && i_wb_rd != '0 && i_wb_rd == i_ex_rs1) fwd_rs1 = i_wb_value;
    else fwd_rs1 = i_ex_rs1_data;

    if (o_mem_ctrl.rd_valid && o_mem_rd != '0 && o_mem_rd == i_ex_rs2) fwd_rs2 = mem_value;
    else if (i_wb_we && i_wb_rd != '0 && i_wb_rd == i_ex_rs2) fwd_rs2 = i_wb_value;
    else fwd_rs2 = i_ex_rs2_data;
  end

  assign alu_a = i_ex_ctrl.use_pc ? i_ex_pc : fwd_rs1;
  assign alu_b = i_ex_ctrl.use_imm ? i_ex_imm : fwd_rs2;

  always_comb begin
    case (i_ex_ctrl.alu_op)
      rv_pkg::alu_sub: alu_out = alu_a - alu_b;
      rv_pkg::alu_and: alu_out = alu_a & alu_b;
      rv_pkg::alu_or:  alu_out = alu_a | alu_b;
      rv_pkg::alu_xor: alu_out = alu_a ^ alu_b;
      rv_pkg::alu_slt: alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
      rv_pkg::alu_pass_b: alu_out = alu_b;
      default: alu_out = alu_a + alu_b;
    endcase
  end

  always_comb begin
    case (i_ex_ctrl.cmp_op)
      rv_pkg::cmp_ne: cmp_true = (fwd_rs1 != fwd_rs2);
      rv_pkg::cmp_lt: cmp_true = ($signed(fwd_rs1) < $signed(fwd_rs2));
      default: cmp_true = (fwd_rs1 == fwd_rs2);
    endcase
  end

  assign o_redirect = i_ex_ctrl.is_jump || (i_ex_ctrl.is_branch && cmp_true);
  assign o_target   = alu_out; // pc + imm for branches and JAL

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) o_mem_ctrl <= '0;
    else if (i_advance) o_mem_ctrl <= i_ex_ctrl;
  end

  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_mem_alu        <= alu_out;
      o_mem_store_data <= fwd_rs2;
      o_mem_pc         <= i_ex_pc;
      o_mem_rd         <= i_ex_rd;
    end
  end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module fetch_stage (
  input  logic               clk,
  input  logic               i_arst_n,
  input  logic               i_advance,
  input  logic               i_hold_front,
  input  logic               i_redirect,
  input  logic [`RV_XLEN-1:0] i_target,
  input  logic [`RV_XLEN-1:0] i_instr,
  output logic [`RV_XLEN-1:0] o_pc,
  output logic [`RV_XLEN-1:0] o_id_instr,
  output logic [`RV_XLEN-1:0] o_id_pc
);

  localparam logic [`RV_XLEN-1:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pc       <= `RV_RESET_PC;
      o_id_instr <= NOP_INSTR;
    end else if (i_advance) begin
      if (i_redirect) begin
        o_pc       <= i_target;
        o_id_instr <= NOP_INSTR; // Drop wrong-path fetch
      end else if (!i_hold_front) begin
        o_pc       <= o_pc + `RV_PC_STEP;
        o_id_instr <= i_instr;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_advance && !i_redirect && !i_hold_front) begin
      o_id_pc <= o_pc;
    end
  end

  // Targets from EX must keep fetch word-aligned
  a_pc_aligned: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    o_pc[1:0] == 2'b00
  );

endmodule

// ==== files.f ====
+incdir+.
rv_pkg.sv
fetch_stage.sv
decode_stage.sv
regfile.sv
execute_stage.sv
writeback_stage.sv
pipeline_ctrl.sv
rv_core.sv
tb_rv_core.sv

// ==== pipeline_ctrl.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module pipeline_ctrl (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_i_mem_resp,
  input  logic                 i_d_mem_req,
  input  logic                 i_d_mem_resp,
  input  logic                 i_ex_is_load,
  input  logic [`RV_REG_AW-1:0] i_ex_rd,
  input  logic [`RV_REG_AW-1:0] i_id_rs1,
  input  logic [`RV_REG_AW-1:0] i_id_rs2,
  input  logic                 i_redirect,
  output logic                 o_advance,
  output logic                 o_hold_front,
  output logic                 o_bubble
);

  rv_pkg::stall_state_e state, state_nxt;
  logic                 mem_stall;
  logic                 load_use;

  assign mem_stall = !i_i_mem_resp || (i_d_mem_req && !i_d_mem_resp);

  // ID reads a register the load in EX has not fetched yet
  assign load_use = i_ex_is_load && i_ex_rd != '0 &&
                    (i_ex_rd == i_id_rs1 || i_ex_rd == i_id_rs2);

  assign o_advance    = !mem_stall;
  assign o_hold_front = load_use && state != rv_pkg::st_load_hold; // One bubble per load
  assign o_bubble     = o_hold_front;

  always_comb begin
    if (mem_stall) state_nxt = rv_pkg::st_mem_wait;
    else if (o_hold_front) state_nxt = rv_pkg::st_load_hold;
    else state_nxt = rv_pkg::st_run;
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) state <= rv_pkg::st_run;
    else state <= state_nxt;
  end

  // A load in EX never redirects, so the hold and the flush stay apart
  a_hold_vs_redirect: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    !(o_hold_front && i_redirect)
  );

endmodule

// ==== regfile.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module regfile (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_we,
  input  logic [`RV_REG_AW-1:0] i_waddr,
  input  logic [`RV_XLEN-1:0]   i_wdata,
  input  logic [`RV_REG_AW-1:0] i_raddr_a,
  input  logic [`RV_REG_AW-1:0] i_raddr_b,
  output logic [`RV_XLEN-1:0]   o_rdata_a,
  output logic [`RV_XLEN-1:0]   o_rdata_b
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) regs[i] <= '0;
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // WB write seen by ID in the same cycle
  always_comb begin
    if (i_raddr_a == '0) o_rdata_a = '0;
    else if (i_we && i_waddr == i_raddr_a) o_rdata_a = i_wdata;
    else o_rdata_a = regs[i_raddr_a];

    if (i_raddr_b == '0) o_rdata_b = '0;
    else if (i_we && i_waddr == i_raddr_b) o_rdata_b = i_wdata;
    else o_rdata_b = regs[i_raddr_b];
  end

  // Decode drops rd_valid for x0, so no data should ever target it
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!i_arst_n)
    i_we |-> (i_waddr != '0 || i_wdata == '0)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_rv_core -f files.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== rv_core.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core (
  input  logic               clk,
  input  logic               i_arst_n,
  output logic [`RV_XLEN-1:0] o_i_mem_addr,
  input  logic [`RV_XLEN-1:0] i_i_mem_data,
  input  logic               i_i_mem_resp,
  output logic [`RV_XLEN-1:0] o_d_mem_addr,
  output logic [`RV_XLEN-1:0] o_d_mem_wdata,
  output logic               o_d_mem_read,
  output logic               o_d_mem_write,
  input  logic [`RV_XLEN-1:0] i_d_mem_data,
  input  logic               i_d_mem_resp
);

  logic                  advance, hold_front, bubble;
  logic                  redirect;
  logic [`RV_XLEN-1:0]   target;
  logic [`RV_XLEN-1:0]   id_instr, id_pc;
  logic [`RV_REG_AW-1:0] rs1, rs2;
  logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
  rv_pkg::ctrl_t         ex_ctrl, mem_ctrl;
  logic [`RV_XLEN-1:0]   ex_pc, ex_imm, ex_rs1_data, ex_rs2_data;
  logic [`RV_REG_AW-1:0] ex_rs1, ex_rs2, ex_rd;
  logic [`RV_XLEN-1:0]   mem_alu, mem_store_data, mem_pc;
  logic [`RV_REG_AW-1:0] mem_rd, wb_rd;
  logic                  wb_we;
  logic [`RV_XLEN-1:0]   wb_value;

  fetch_stage u_fetch (
    .clk(clk), .i_arst_n(i_arst_n), .i_advance(advance), .i_hold_front(hold_front),
    .i_redirect(redirect), .i_target(target), .i_instr(i_i_mem_data),
    .o_pc(o_i_mem_addr), .o_id_instr(id_instr), .o_id_pc(id_pc)
  );

  decode_stage u_decode (
    .clk(clk), .i_arst_n(i_arst_n), .i_advance(advance), .i_bubble(bubble),
    .i_flush(redirect), .i_instr(id_instr), .i_pc(id_pc),
    .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .o_rs1(rs1), .o_rs2(rs2),
    .o_ex_ctrl(ex_ctrl), .o_ex_pc(ex_pc), .o_ex_imm(ex_imm),
    .o_ex_rs1_data(ex_rs1_data), .o_ex_rs2_data(ex_rs2_data),
    .o_ex_rs1(ex_rs1), .o_ex_rs2(ex_rs2), .o_ex_rd(ex_rd)
  );

  regfile u_regfile (
    .clk(clk), .i_arst_n(i_arst_n), .i_we(wb_we), .i_waddr(wb_rd), .i_wdata(wb_value),
    .i_raddr_a(rs1), .i_raddr_b(rs2), .o_rdata_a(rs1_data), .o_rdata_b(rs2_data)
  );

  execute_stage u_execute (
    .clk(clk), .i_arst_n(i_arst_n), .i_advance(advance), .i_ex_ctrl(ex_ctrl),
    .i_ex_pc(ex_pc), .i_ex_imm(ex_imm), .i_ex_rs1_data(ex_rs1_data),
    .i_ex_rs2_data(ex_rs2_data), .i_ex_rs1(ex_rs1), .i_ex_rs2(ex_rs2), .i_ex_rd(ex_rd),
    .i_wb_rd(wb_rd), .i_wb_we(wb_we), .i_wb_value(wb_value),
    .o_redirect(redirect), .o_target(target), .o_mem_ctrl(mem_ctrl), .o_mem_alu(mem_alu),
    .o_mem_store_data(mem_store_data), .o_mem_pc(mem_pc), .o_mem_rd(mem_rd)
  );

  writeback_stage u_writeback (
    .clk(clk), .i_arst_n(i_arst_n), .i_advance(advance), .i_mem_ctrl(mem_ctrl),
    .i_mem_alu(mem_alu), .i_mem_store_data(mem_store_data), .i_mem_pc(mem_pc),
    .i_mem_rd(mem_rd), .i_d_mem_data(i_d_mem_data),
    .o_d_mem_addr(o_d_mem_addr), .o_d_mem_wdata(o_d_mem_wdata),
    .o_d_mem_read(o_d_mem_read), .o_d_mem_write(o_d_mem_write),
    .o_wb_rd(wb_rd), .o_wb_we(wb_we), .o_wb_value(wb_value)
  );

  pipeline_ctrl u_ctrl (
    .clk(clk), .i_arst_n(i_arst_n), .i_i_mem_resp(i_i_mem_resp),
    .i_d_mem_req(o_d_mem_read || o_d_mem_write), .i_d_mem_resp(i_d_mem_resp),
    .i_ex_is_load(ex_ctrl.mem_read), .i_ex_rd(ex_rd), .i_id_rs1(rs1), .i_id_rs2(rs2),
    .i_redirect(redirect), .o_advance(advance), .o_hold_front(hold_front),
    .o_bubble(bubble)
  );

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_imm    = 7'b0010011,
    op_reg    = 7'b0110011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_branch = 7'b1100011,
    op_jal    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {cmp_eq, cmp_ne, cmp_lt} cmp_op_e;

  typedef enum logic [1:0] {wb_alu, wb_mem, wb_pc_plus4} wb_sel_e;

  typedef enum logic [1:0] {st_run, st_load_hold, st_mem_wait} stall_state_e;

  // All zero is a bubble
  typedef struct packed {
    alu_op_e alu_op;
    cmp_op_e cmp_op;
    wb_sel_e wb_sel;
    logic    use_imm;   // ALU b from immediate
    logic    use_pc;    // ALU a from PC
    logic    rd_valid;
    logic    mem_read;
    logic    mem_write;
    logic    is_branch;
    logic    is_jump;
  } ctrl_t;

endpackage

// ==== rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data and address width
`define RV_XLEN 32

`define RV_NREGS 32
`define RV_REG_AW 5

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000
`define RV_PC_STEP 32'd4

`endif

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_core;

  localparam int RESET_CYCLES = 5;
  localparam int WAIT_LIMIT   = 400; // Per run, ample even with random gaps
  localparam int DRAIN_CYCLES = 20;  // Time for stray stores to show up
  // Reset check plus five runs of reset, wait and drain stay far below this
  localparam int MAX_CYCLES   = 4000;
  localparam logic [6:0] OPC_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_LOAD = 7'b0000011;

  logic                clk = 1'b0;
  logic                i_arst_n = 1'b0;
  logic [`RV_XLEN-1:0] o_i_mem_addr;
  logic [`RV_XLEN-1:0] i_i_mem_data;
  logic                i_i_mem_resp = 1'b1;
  logic [`RV_XLEN-1:0] o_d_mem_addr;
  logic [`RV_XLEN-1:0] o_d_mem_wdata;
  logic                o_d_mem_read;
  logic                o_d_mem_write;
  logic [`RV_XLEN-1:0] i_d_mem_data;
  logic                i_d_mem_resp = 1'b1;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] store_addr [$];
  logic [31:0] store_data [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];
  logic [31:0] prog_pc = '0;
  logic        gaps_on = 1'b0;
  integer      seed = 32'h9e8d;
  int          errors = 0;
  int          mon_errors = 0;
  int          cycles = 0;
  int          runs = 0;

  logic        d_waiting = 1'b0;
  logic        i_waiting = 1'b0;
  logic [31:0] held_addr, held_wdata, held_pc;
  logic        held_read, held_write;

  rv_core i_dut (
    .clk(clk), .i_arst_n(i_arst_n),
    .o_i_mem_addr(o_i_mem_addr), .i_i_mem_data(i_i_mem_data), .i_i_mem_resp(i_i_mem_resp),
    .o_d_mem_addr(o_d_mem_addr), .o_d_mem_wdata(o_d_mem_wdata),
    .o_d_mem_read(o_d_mem_read), .o_d_mem_write(o_d_mem_write),
    .i_d_mem_data(i_d_mem_data), .i_d_mem_resp(i_d_mem_resp)
  );

  always #2 clk = ~clk;

  assign i_i_mem_data = imem[o_i_mem_addr[9:2]];
  assign i_d_mem_data = (o_d_mem_read === 1'b1) ? dmem[o_d_mem_addr[9:2]] : 32'h0; // Idle bus reads 0

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}; // SW only
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // Initial data memory contents, unique per word
  function automatic logic [31:0] fill_word(input logic [7:0] idx);
    return 32'hc0de_0000 ^ {22'b0, idx, 2'b00};
  endfunction

  function void emit(input logic [31:0] instr);
    imem[prog_pc[9:2]] = instr;
    prog_pc = prog_pc + 32'd4;
  endfunction

  function void expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
  endfunction

  // Fetch may stall any cycle; data answers only in cycles that also fetch
  always @(posedge clk) begin : drive_resp
    logic fetch_ok;
    fetch_ok = !gaps_on || (($random(seed) & 3) != 0);
    i_i_mem_resp <= fetch_ok;
    i_d_mem_resp <= fetch_ok && (!gaps_on || (($random(seed) & 3) != 0));
  end

  // Data memory, store log and request stability
  always @(posedge clk) begin
    if (!i_arst_n) begin
      for (int i = 0; i < 256; i++) dmem[i[7:0]] <= fill_word(i[7:0]);
      store_addr.delete();
      store_data.delete();
      d_waiting <= 1'b0;
      i_waiting <= 1'b0;
    end else begin
      if (d_waiting && o_d_mem_addr != held_addr) begin
        $display("Error at %0t: o_d_mem_addr = %h, expected %h", $time, o_d_mem_addr, held_addr);
        mon_errors++;
      end
      if (d_waiting && o_d_mem_wdata != held_wdata) begin
        $display("Error at %0t: o_d_mem_wdata = %h, expected %h", $time, o_d_mem_wdata,
                 held_wdata);
        mon_errors++;
      end
      if (d_waiting && o_d_mem_read != held_read) begin
        $display("Error at %0t: o_d_mem_read = %b, expected %b", $time, o_d_mem_read,
                 held_read);
        mon_errors++;
      end
      if (d_waiting && o_d_mem_write != held_write) begin
        $display("Error at %0t: o_d_mem_write = %b, expected %b", $time, o_d_mem_write,
                 held_write);
        mon_errors++;
      end
      if (i_waiting && o_i_mem_addr != held_pc) begin
        $display("Error at %0t: o_i_mem_addr = %h, expected %h", $time, o_i_mem_addr, held_pc);
        mon_errors++;
      end
      if (o_d_mem_write && i_d_mem_resp) begin
        store_addr.push_back(o_d_mem_addr);
        store_data.push_back(o_d_mem_wdata);
        dmem[o_d_mem_addr[9:2]] <= o_d_mem_wdata;
      end
      d_waiting  <= (o_d_mem_read || o_d_mem_write) && !i_d_mem_resp;
      i_waiting  <= !i_i_mem_resp;
      held_addr  <= o_d_mem_addr;
      held_wdata <= o_d_mem_wdata;
      held_read  <= o_d_mem_read;
      held_write <= o_d_mem_write;
      held_pc    <= o_i_mem_addr;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Puts the core in reset and fills the program space with NOPs
  task start_test(input bit gaps);
    gaps_on = gaps;
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = i_type({2'b00, i[7:0], 2'b00}, 5'd0, 3'b000, 5'd0, OPC_IMM);
    end
    @(posedge clk);
    i_arst_n <= 1'b0;
    exp_addr.delete();
    exp_data.delete();
    prog_pc = '0;
  endtask

  task check_bus_idle(input bit pc_check);
    if (o_d_mem_read !== 1'b0) begin
      $display("Error at %0t: o_d_mem_read = %b, expected 0", $time, o_d_mem_read);
      errors++;
    end
    if (o_d_mem_write !== 1'b0) begin
      $display("Error at %0t: o_d_mem_write = %b, expected 0", $time, o_d_mem_write);
      errors++;
    end
    if (pc_check && o_i_mem_addr !== `RV_RESET_PC) begin
      $display("Error at %0t: o_i_mem_addr = %h, expected %h", $time, o_i_mem_addr,
               `RV_RESET_PC);
      errors++;
    end
  endtask

  task check_reset();
    start_test(1'b0);
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_bus_idle(1'b1);
    end
    @(posedge clk);
    i_arst_n <= 1'b1;
    @(negedge clk);
    check_bus_idle(1'b1);
    repeat (3) begin
      @(negedge clk);
      check_bus_idle(1'b0);
    end
  endtask

  // Releases reset, waits for the expected stores and compares them in order
  task run_and_compare(input string name);
    int waited;
    int n;
    runs++;
    $display("Running %s, random gaps %0d", name, gaps_on);
    repeat (RESET_CYCLES) @(posedge clk);
    i_arst_n <= 1'b1;
    waited = 0;
    while (store_addr.size() < exp_addr.size() && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    repeat (DRAIN_CYCLES) @(negedge clk);
    if (store_addr.size() != exp_addr.size()) begin
      $display("%s: expected %0d stores but saw %0d", name, exp_addr.size(), store_addr.size());
      errors++;
    end
    n = (store_addr.size() < exp_addr.size()) ? store_addr.size() : exp_addr.size();
    for (int i = 0; i < n; i++) begin
      if (store_addr[i] != exp_addr[i]) begin
        $display("Error at %0t: %s store %0d o_d_mem_addr = %h, expected %h", $time, name, i,
                 store_addr[i], exp_addr[i]);
        errors++;
      end
      if (store_data[i] != exp_data[i]) begin
        $display("Error at %0t: %s store %0d o_d_mem_wdata = %h, expected %h", $time, name, i,
                 store_data[i], exp_data[i]);
        errors++;
      end
    end
  endtask

  task test_alu_chain(input bit gaps);
    logic [31:0] x1, x2, x3, x4, x5, x6, x7, x8, x9, x10;
    start_test(gaps);
    x1  = {20'h12345, 12'h000};
    x2  = x1 + 32'h678;
    x3  = x2 + x1;
    x4  = x3 - x2;
    x5  = x4 & x3;
    x6  = x5 | x4;
    x7  = x6 ^ x5;
    x8  = ($signed(x7) < $signed(x6)) ? 32'd1 : 32'd0;
    x9  = 32'hffff_fffb;
    x10 = ($signed(x9) < $signed(x8)) ? 32'd1 : 32'd0;
    emit(u_type(20'h12345, 5'd1));
    emit(i_type(12'h678, 5'd1, 3'b000, 5'd2, OPC_IMM));
    emit(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3)); // x1 from WB, x2 from MEM
    emit(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
    emit(r_type(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
    emit(r_type(7'h00, 5'd4, 5'd5, 3'b110, 5'd6));
    emit(r_type(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));
    emit(r_type(7'h00, 5'd6, 5'd7, 3'b010, 5'd8));
    emit(i_type(12'hffb, 5'd0, 3'b000, 5'd9, OPC_IMM));
    emit(r_type(7'h00, 5'd8, 5'd9, 3'b010, 5'd10)); // Negative operand
    emit(s_type(12'd28, 5'd10, 5'd0));              // Store data from MEM
    emit(s_type(12'd0, 5'd2, 5'd0));
    emit(s_type(12'd4, 5'd3, 5'd0));
    emit(s_type(12'd8, 5'd4, 5'd0));
    emit(s_type(12'd12, 5'd5, 5'd0));
    emit(s_type(12'd16, 5'd6, 5'd0));
    emit(s_type(12'd20, 5'd7, 5'd0));
    emit(s_type(12'd24, 5'd8, 5'd0));
    emit(j_type(21'd0, 5'd0));
    expect_store(32'd28, x10);
    expect_store(32'd0, x2);
    expect_store(32'd4, x3);
    expect_store(32'd8, x4);
    expect_store(32'd12, x5);
    expect_store(32'd16, x6);
    expect_store(32'd20, x7);
    expect_store(32'd24, x8);
    run_and_compare("ALU chain");
  endtask

  task test_load_use(input bit gaps);
    logic [31:0] x1, x3, x5, x6;
    start_test(gaps);
    x1 = 32'h123;
    x3 = x1 + 32'd7;
    x5 = x1 + x1;
    x6 = fill_word(8'd32); // Word at 128 is never written
    emit(i_type(12'h123, 5'd0, 3'b000, 5'd1, OPC_IMM));
    emit(s_type(12'd64, 5'd1, 5'd0));
    emit(i_type(12'd64, 5'd0, 3'b010, 5'd2, OPC_LOAD));
    emit(i_type(12'd7, 5'd2, 3'b000, 5'd3, OPC_IMM)); // Needs x2 at once
    emit(s_type(12'd68, 5'd3, 5'd0));
    emit(i_type(12'd64, 5'd0, 3'b010, 5'd4, OPC_LOAD));
    emit(r_type(7'h00, 5'd4, 5'd4, 3'b000, 5'd5));
    emit(s_type(12'd72, 5'd5, 5'd0));
    emit(i_type(12'd128, 5'd0, 3'b010, 5'd6, OPC_LOAD));
    emit(s_type(12'd76, 5'd6, 5'd0));
    emit(j_type(21'd0, 5'd0));
    expect_store(32'd64, x1);
    expect_store(32'd68, x3);
    expect_store(32'd72, x5);
    expect_store(32'd76, x6);
    run_and_compare("load-use");
  endtask

  // Stores at 0x100 and above sit on paths that must not execute
  task test_control_flow();
    logic [31:0] x1, x2, x3, link;
    start_test(1'b0);
    x1 = 32'd5;
    x2 = 32'd5;
    x3 = 32'hffff_fffd;
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_IMM));
    emit(i_type(12'd5, 5'd0, 3'b000, 5'd2, OPC_IMM));
    emit(i_type(12'hffd, 5'd0, 3'b000, 5'd3, OPC_IMM));
    emit(b_type(13'd12, 5'd2, 5'd1, 3'b000)); // beq x1, x2 taken
    emit(s_type(12'h100, 5'd1, 5'd0));
    emit(s_type(12'h104, 5'd1, 5'd0));
    emit(s_type(12'h080, 5'd3, 5'd0));
    emit(b_type(13'd8, 5'd2, 5'd1, 3'b001));  // bne x1, x2 not taken
    emit(s_type(12'h084, 5'd1, 5'd0));
    emit(b_type(13'd12, 5'd1, 5'd3, 3'b100)); // blt x3, x1 taken
    emit(s_type(12'h108, 5'd1, 5'd0));
    emit(s_type(12'h10c, 5'd1, 5'd0));
    emit(b_type(13'd8, 5'd3, 5'd1, 3'b100));  // blt x1, x3 not taken
    emit(s_type(12'h088, 5'd2, 5'd0));
    emit(b_type(13'd8, 5'd3, 5'd1, 3'b000));  // beq x1, x3 not taken
    emit(b_type(13'd12, 5'd3, 5'd1, 3'b001)); // bne x1, x3 taken
    emit(s_type(12'h110, 5'd1, 5'd0));
    emit(s_type(12'h114, 5'd1, 5'd0));
    link = prog_pc + 32'd4;
    emit(j_type(21'd12, 5'd4));
    emit(s_type(12'h118, 5'd1, 5'd0));
    emit(s_type(12'h11c, 5'd1, 5'd0));
    emit(s_type(12'h08c, 5'd4, 5'd0));
    emit(j_type(21'd0, 5'd0));
    expect_store(32'h80, x3);
    expect_store(32'h84, x1);
    expect_store(32'h88, x2);
    expect_store(32'h8c, link);
    run_and_compare("control flow");
  endtask

  initial begin
    check_reset();
    test_alu_chain(1'b0);
    test_load_use(1'b0);
    test_control_flow();
    test_alu_chain(1'b1);
    test_load_use(1'b1);
    $display("Summary: %0d check errors and %0d bus errors over %0d program runs", errors,
             mon_errors, runs);
    if (errors + mon_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== writeback_stage.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module writeback_stage (
  input  logic                 clk,
  input  logic                 i_arst_n,
  input  logic                 i_advance,
  input  rv_pkg::ctrl_t        i_mem_ctrl,
  input  logic [`RV_XLEN-1:0]   i_mem_alu,
  input  logic [`RV_XLEN-1:0]   i_mem_store_data,
  input  logic [`RV_XLEN-1:0]   i_mem_pc,
  input  logic [`RV_REG_AW-1:0] i_mem_rd,
  input  logic [`RV_XLEN-1:0]   i_d_mem_data,
  output logic [`RV_XLEN-1:0]   o_d_mem_addr,
  output logic [`RV_XLEN-1:0]   o_d_mem_wdata,
  output logic                 o_d_mem_read,
  output logic                 o_d_mem_write,
  output logic [`RV_REG_AW-1:0] o_wb_rd,
  output logic                 o_wb_we,
  output logic [`RV_XLEN-1:0]   o_wb_value
);

  logic [`RV_XLEN-1:0] result;

  // Held steady by the freeze until the memory answers
  assign o_d_mem_addr  = {i_mem_alu[`RV_XLEN-1:2], 2'b00};
  assign o_d_mem_wdata = i_mem_store_data;
  assign o_d_mem_read  = i_mem_ctrl.mem_read;
  assign o_d_mem_write = i_mem_ctrl.mem_write;

  always_comb begin
    case (i_mem_ctrl.wb_sel)
      rv_pkg::wb_mem:      result = i_d_mem_data;
      rv_pkg::wb_pc_plus4: result = i_mem_pc + `RV_PC_STEP;
      default:             result = i_mem_alu;
    endcase
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) o_wb_we <= 1'b0;
    else if (i_advance) o_wb_we <= i_mem_ctrl.rd_valid;
  end

  always_ff @(posedge clk) begin
    if (i_advance) begin
      o_wb_rd    <= i_mem_rd;
      o_wb_value <= result;
    end
  end

endmodule
